/* Bender.yml */
package:
  name: pic

sources:
  - verilog/pic_pkg.sv
  - verilog/pic_bus_arbiter.sv
  - verilog/pic_regs.sv
  - verilog/pic_request_encoder.sv
  - verilog/pic_core_router.sv
  - verilog/pic_top.sv
  - target: test
    files:
      - tb/pic_tb.sv

/* project.f */
verilog/pic_pkg.sv
verilog/pic_bus_arbiter.sv
verilog/pic_regs.sv
verilog/pic_request_encoder.sv
verilog/pic_core_router.sv
verilog/pic_top.sv
tb/pic_tb.sv

/* tb/pic_tb.sv */
`timescale 1ns/10ps

module pic_tb;

	// cycles any single wait may take before giving up
	localparam int BUS_TIMEOUT = 20;
	localparam int OUT_TIMEOUT = 20;

	logic clk;
	logic rst_i;
	pic_pkg::reg_req_t req [pic_pkg::NUM_CORES];
	pic_pkg::reg_rsp_t rsp [pic_pkg::NUM_CORES];
	pic_pkg::irq_vec_t irq_in;
	logic nmi_in;
	pic_pkg::core_irq_t irq_out [pic_pkg::NUM_CORES];
	logic [pic_pkg::NUM_CORES-1:0] nmi_out;

	integer seed = 54;
	int ack_count [pic_pkg::NUM_CORES] = '{0, 0};

	// ============================================================
	// reference model built from the writes issued below
	// ============================================================

	pic_pkg::irq_vec_t m_enable;
	pic_pkg::irq_vec_t m_sense;
	pic_pkg::irq_vec_t m_latch;
	pic_pkg::cause_t m_cause [pic_pkg::NUM_IRQ];
	pic_pkg::level_t m_level [pic_pkg::NUM_IRQ];
	pic_pkg::core_id_t m_core [pic_pkg::NUM_IRQ];

	pic_top dut
	(
		.clk(clk),
		.rst_i(rst_i),
		.req_i(req),
		.rsp_o(rsp),
		.irq_i(irq_in),
		.nmi_i(nmi_in),
		.irq_o(irq_out),
		.nmi_o(nmi_out)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	task automatic fail_stop();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_stop();
		end
	endtask

	// lowest enabled pending line from 1 up or -1 when none
	function automatic int lowest_pending();
		pic_pkg::irq_vec_t pend;
		int id;
		pend = m_enable & ((m_sense & m_latch) | (~m_sense & irq_in));
		id = -1;
		for (int n = 31; n >= 1; n--)
			if (pend[n])
				id = n;
		return id;
	endfunction

	function automatic pic_pkg::core_irq_t expected_irq(input int core);
		pic_pkg::core_irq_t r;
		int w;
		r = '0;
		w = lowest_pending();
		if (w > 0 && int'(m_core[w]) == core)
		begin
			r.level = m_level[w];
			r.cause = m_cause[w];
		end
		return r;
	endfunction

	// control word holds cause in 7 to 0, level in 11 to 8, enable 16, sense 17, core 24
	function automatic pic_pkg::word_t line_word(input int line);
		pic_pkg::word_t w;
		w = '0;
		w[7:0] = m_cause[line];
		w[11:8] = m_level[line];
		w[16] = m_enable[line];
		w[17] = m_sense[line];
		w[24] = m_core[line];
		return w;
	endfunction

	function automatic int pick_line();
		return 1 + ({$random(seed)} % 31);
	endfunction

	// never zero so an active output always differs from idle
	function automatic pic_pkg::level_t pick_level();
		return pic_pkg::level_t'(1 + ({$random(seed)} % 15));
	endfunction

	function automatic pic_pkg::reg_addr_t global_addr(input logic [5:0] word);
		return {word, 2'b00};
	endfunction

	function automatic pic_pkg::reg_addr_t line_addr(input int line);
		return pic_pkg::REG_LINE_BASE + pic_pkg::reg_addr_t'(line << 2);
	endfunction

	// ============================================================
	// register bus
	// ============================================================

	// request held from a falling edge until ack and then dropped
	task automatic bus_access(input int port, input logic we, input logic inta,
		input pic_pkg::reg_addr_t addr, input pic_pkg::word_t wdata,
		output pic_pkg::word_t rdata);
		pic_pkg::reg_req_t r;
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		rdata = '0;
		r = '0;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we = we;
		r.inta = inta;
		r.addr = addr;
		r.wdata = wdata;
		@(negedge clk);
		req[port] = r;
		while (!done)
		begin
			@(negedge clk);
			cycles++;
			if (rsp[port].ack)
			begin
				rdata = rsp[port].rdata;
				done = 1'b1;
			end
			else if (cycles > BUS_TIMEOUT)
			begin
				$display("port %0d got no ack within %0d cycles", port, BUS_TIMEOUT);
				fail_stop();
			end
		end
		req[port] = '0;
	endtask

	task automatic reg_write(input int port, input pic_pkg::reg_addr_t addr,
		input pic_pkg::word_t data);
		pic_pkg::word_t unused;
		bus_access(port, 1'b1, 1'b0, addr, data, unused);
	endtask

	task automatic reg_read(input int port, input pic_pkg::reg_addr_t addr,
		output pic_pkg::word_t data);
		bus_access(port, 1'b0, 1'b0, addr, '0, data);
	endtask

	task automatic inta_read(input int port, output pic_pkg::word_t data);
		bus_access(port, 1'b0, 1'b1, '0, '0, data);
	endtask

	task automatic write_line(input int port, input int line, input pic_pkg::cause_t cause,
		input pic_pkg::level_t level, input logic en, input logic sense,
		input pic_pkg::core_id_t core);
		pic_pkg::word_t w;
		w = '0;
		w[7:0] = cause;
		w[11:8] = level;
		w[16] = en;
		w[17] = sense;
		w[24] = core;
		reg_write(port, line_addr(line), w);
		m_cause[line] = cause;
		m_level[line] = level;
		m_core[line] = core;
		m_enable[line] = en;
		m_sense[line] = sense;
	endtask

	// ============================================================
	// request lines and outputs
	// ============================================================

	// a rising input also sets the line's latch
	task automatic drive_line(input int line, input logic value);
		@(negedge clk);
		if (value && !irq_in[line])
			m_latch[line] = 1'b1;
		irq_in[line] = value;
	endtask

	// wait until both cores and nmi show what the model predicts
	task automatic wait_outputs();
		pic_pkg::core_irq_t e0;
		pic_pkg::core_irq_t e1;
		logic [1:0] en;
		int cycles;
		cycles = 0;
		@(negedge clk);
		e0 = expected_irq(0);
		e1 = expected_irq(1);
		en = {2{nmi_in & m_enable[0]}};
		while (irq_out[0] !== e0 || irq_out[1] !== e1 || nmi_out !== en)
		begin
			if (cycles >= OUT_TIMEOUT)
			begin
				if (irq_out[0] !== e0)
					$display("Error at %0t: irq_o[0] is %h, expected %h", $time, irq_out[0], e0);
				if (irq_out[1] !== e1)
					$display("Error at %0t: irq_o[1] is %h, expected %h", $time, irq_out[1], e1);
				if (nmi_out !== en)
					$display("Error at %0t: nmi_o is %b, expected %b", $time, nmi_out, en);
				fail_stop();
			end
			@(negedge clk);
			cycles++;
			e0 = expected_irq(0);
			e1 = expected_irq(1);
			en = {2{nmi_in & m_enable[0]}};
		end
	endtask

	task automatic clear_enables();
		reg_write(0, global_addr(pic_pkg::REG_ENABLE), '0);
		m_enable = '0;
		@(negedge clk);
		irq_in = '0;
		wait_outputs();
	endtask

	// ============================================================
	// bus protocol checks
	// ============================================================

	always @(negedge clk)
	begin
		if (!rst_i)
		begin
			if (rsp[0].ack)
				ack_count[0] <= ack_count[0] + 1;
			if (rsp[1].ack)
				ack_count[1] <= ack_count[1] + 1;
		end
	end

	ack_with_stb0: assert property (@(negedge clk) disable iff (rst_i)
		rsp[0].ack |-> (req[0].cyc && req[0].stb))
	else
	begin
		$display("port 0 saw an ack while its stb was low");
		fail_stop();
	end

	ack_with_stb1: assert property (@(negedge clk) disable iff (rst_i)
		rsp[1].ack |-> (req[1].cyc && req[1].stb))
	else
	begin
		$display("port 1 saw an ack while its stb was low");
		fail_stop();
	end

	ack_single_pulse: assert property (@(negedge clk) disable iff (rst_i)
		(rsp[0].ack || rsp[1].ack) |=> !(rsp[0].ack || rsp[1].ack))
	else
	begin
		$display("ack stayed high for more than one cycle");
		fail_stop();
	end

	one_port_acked: assert property (@(negedge clk) disable iff (rst_i)
		!(rsp[0].ack && rsp[1].ack))
	else
	begin
		$display("both ports saw an ack in the same cycle");
		fail_stop();
	end

	// the winner goes to one core only
	one_core_active: assert property (@(negedge clk) disable iff (rst_i)
		!((irq_out[0] != '0) && (irq_out[1] != '0)))
	else
	begin
		$display("both cores show an interrupt at once");
		fail_stop();
	end

	// ============================================================
	// stimulus
	// ============================================================

	initial
	begin
		pic_pkg::word_t data;
		pic_pkg::cause_t cs;
		pic_pkg::cause_t cs2;
		pic_pkg::level_t lvl;
		pic_pkg::level_t lvl2;
		pic_pkg::core_id_t core;
		int a;
		int b;
		int t;
		int count0;
		int count1;

		rst_i = 1'b1;
		req[0] = '0;
		req[1] = '0;
		irq_in = '0;
		nmi_in = 1'b0;
		m_enable = '0;
		m_sense = '1;
		m_latch = '0;
		for (int n = 0; n < pic_pkg::NUM_IRQ; n++)
		begin
			m_cause[n] = '0;
			m_level[n] = 4'd8;
			m_core[n] = '0;
		end
		// four rising edges in reset
		repeat (4)
			@(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		// reset state
		@(negedge clk);
		check_value("irq_o[0]", irq_out[0], 0);
		check_value("irq_o[1]", irq_out[1], 0);
		check_value("nmi_o", nmi_out, 0);
		reg_read(0, global_addr(pic_pkg::REG_ENABLE), data);
		check_value("enable", data, 0);
		a = pick_line();
		reg_read(1, line_addr(a), data);
		check_value("line word", data, line_word(a));

		// level request on core 0
		a = pick_line();
		cs = pic_pkg::cause_t'($random(seed));
		lvl = pick_level();
		write_line(0, a, cs, lvl, 1'b1, 1'b0, 1'b0);
		drive_line(a, 1'b1);
		wait_outputs();
		check_value("irq_o[0]", irq_out[0], {lvl, cs});
		check_value("irq_o[1]", irq_out[1], 0);
		drive_line(a, 1'b0);
		wait_outputs();

		// priority and routing between two lines
		clear_enables();
		a = pick_line();
		b = pick_line();
		while (b == a)
			b = pick_line();
		if (b < a)
		begin
			t = a;
			a = b;
			b = t;
		end
		core = pic_pkg::core_id_t'($random(seed));
		write_line(0, a, pic_pkg::cause_t'($random(seed)), pick_level(), 1'b1, 1'b0, core);
		write_line(1, b, pic_pkg::cause_t'($random(seed)), pick_level(), 1'b1, 1'b0, ~core);
		drive_line(a, 1'b1);
		drive_line(b, 1'b1);
		wait_outputs();
		reg_read(0, global_addr(pic_pkg::REG_STATUS), data);
		check_value("status", data, m_cause[a]);
		reg_write(1, global_addr(pic_pkg::REG_DISABLE_ONE), a);
		m_enable[a] = 1'b0;
		wait_outputs();
		drive_line(a, 1'b0);
		drive_line(b, 1'b0);
		wait_outputs();

		// edge latching, acknowledge and software trigger
		clear_enables();
		a = pick_line();
		reg_write(0, global_addr(pic_pkg::REG_EDGE_RESET), a);
		m_latch[a] = 1'b0;
		write_line(0, a, pic_pkg::cause_t'($random(seed)), pick_level(), 1'b1, 1'b1,
			pic_pkg::core_id_t'($random(seed)));
		wait_outputs();
		drive_line(a, 1'b1);
		drive_line(a, 1'b0);
		wait_outputs();
		inta_read(1, data);
		check_value("inta cause", data, m_cause[a]);
		m_latch[a] = 1'b0;
		wait_outputs();
		reg_write(1, global_addr(pic_pkg::REG_TRIGGER), a);
		m_latch[a] = 1'b1;
		wait_outputs();
		reg_write(0, global_addr(pic_pkg::REG_EDGE_RESET), a);
		m_latch[a] = 1'b0;
		wait_outputs();
		inta_read(0, data);
		check_value("inta cause", data, pic_pkg::SPURIOUS_CAUSE);

		// both ports write in the same cycle
		a = pick_line();
		b = pick_line();
		while (b == a)
			b = pick_line();
		cs = pic_pkg::cause_t'($random(seed));
		cs2 = pic_pkg::cause_t'($random(seed));
		lvl = pick_level();
		lvl2 = pick_level();
		// let the count of the last ack settle first
		@(negedge clk);
		count0 = ack_count[0];
		count1 = ack_count[1];
		fork
			write_line(0, a, cs, lvl, 1'b0, 1'b1, 1'b1);
			write_line(1, b, cs2, lvl2, 1'b0, 1'b0, 1'b0);
		join
		// idle a few cycles so a stray ack would be counted
		repeat (4)
			@(negedge clk);
		check_value("port 0 ack count", ack_count[0] - count0, 1);
		check_value("port 1 ack count", ack_count[1] - count1, 1);
		reg_read(1, line_addr(a), data);
		check_value("line word", data, line_word(a));
		reg_read(0, line_addr(b), data);
		check_value("line word", data, line_word(b));

		// nmi masked by enable bit 0
		clear_enables();
		@(negedge clk);
		nmi_in = 1'b1;
		repeat (5)
		begin
			@(negedge clk);
			check_value("nmi_o", nmi_out, 0);
		end
		reg_write(0, global_addr(pic_pkg::REG_ENABLE_ONE), 0);
		m_enable[0] = 1'b1;
		wait_outputs();
		@(negedge clk);
		nmi_in = 1'b0;
		wait_outputs();
		@(negedge clk);
		nmi_in = 1'b1;
		wait_outputs();
		reg_write(1, global_addr(pic_pkg::REG_DISABLE_ONE), 0);
		m_enable[0] = 1'b0;
		wait_outputs();

		$display("Everything OK");
		$finish;
	end

endmodule

/* verilog/pic_bus_arbiter.sv */
`timescale 1ns/10ps

module pic_bus_arbiter
(
	input logic clk,
	input logic rst_i,
	input pic_pkg::reg_req_t req_i [pic_pkg::NUM_CORES],
	output pic_pkg::reg_rsp_t rsp_o [pic_pkg::NUM_CORES],
	output pic_pkg::reg_req_t bus_req_o,
	input pic_pkg::reg_rsp_t bus_rsp_i
);

	pic_pkg::arb_state_t state_q;
	// port that held the bus most recently
	pic_pkg::core_id_t last_q;
	logic want0;
	logic want1;

	// a port wants the bus while cyc and stb are both up
	assign want0 = req_i[0].cyc & req_i[0].stb;
	assign want1 = req_i[1].cyc & req_i[1].stb;

	// ============================================================
	// grant state
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= pic_pkg::IDLE;
			// pretend core 1 went last so core 0 wins the first tie
			last_q <= 1'b1;
		end
		else
		begin
			case (state_q)
				pic_pkg::IDLE:
				begin
					// on a tie take the port that was not served last
					if (want0 && (!want1 || last_q == 1'b1))
					begin
						state_q <= pic_pkg::BUSY_CORE0;
						last_q <= 1'b0;
					end
					else if (want1)
					begin
						state_q <= pic_pkg::BUSY_CORE1;
						last_q <= 1'b1;
					end
				end
				pic_pkg::BUSY_CORE0,
				pic_pkg::BUSY_CORE1:
				begin
					// the access ends with the slave's ack
					if (bus_rsp_i.ack)
						state_q <= pic_pkg::IDLE;
				end
				default:
					state_q <= pic_pkg::IDLE;
			endcase
		end
	end

	// ============================================================
	// request and response steering
	// ============================================================

	always_comb
	begin
		// nothing reaches the register block while idle
		bus_req_o = '0;
		rsp_o[0] = '0;
		rsp_o[1] = '0;
		case (state_q)
			pic_pkg::BUSY_CORE0:
			begin
				bus_req_o = req_i[0];
				rsp_o[0] = bus_rsp_i;
			end
			pic_pkg::BUSY_CORE1:
			begin
				bus_req_o = req_i[1];
				rsp_o[1] = bus_rsp_i;
			end
			default:
			begin
				bus_req_o = '0;
			end
		endcase
	end

endmodule

/* verilog/pic_core_router.sv */
`timescale 1ns/10ps

module pic_core_router
(
	input logic clk,
	input logic rst_i,
	input pic_pkg::irq_id_t winner_i,
	input logic winner_valid_i,
	input pic_pkg::line_ctrl_t line_ctrl_i [pic_pkg::NUM_IRQ],
	input pic_pkg::irq_vec_t irq_enable_i,
	input logic nmi_i,
	output pic_pkg::core_irq_t irq_o [pic_pkg::NUM_CORES],
	output logic [pic_pkg::NUM_CORES-1:0] nmi_o
);

	pic_pkg::core_irq_t irq_q [pic_pkg::NUM_CORES];
	logic [pic_pkg::NUM_CORES-1:0] nmi_q;
	// control word of the current winner
	pic_pkg::line_ctrl_t sel;

	assign sel = line_ctrl_i[winner_i];

	// ============================================================
	// per-core outputs
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int c = 0; c < pic_pkg::NUM_CORES; c++)
				irq_q[c] <= '0;
			nmi_q <= '0;
		end
		else
		begin
			// only the owning core sees level and cause
			for (int c = 0; c < pic_pkg::NUM_CORES; c++)
			begin
				if (winner_valid_i && sel.core == pic_pkg::core_id_t'(c))
				begin
					irq_q[c].level <= sel.level;
					irq_q[c].cause <= sel.cause;
				end
				else
					irq_q[c] <= '0;
			end
			// nmi goes to every core, masked by enable bit 0
			nmi_q <= {pic_pkg::NUM_CORES{nmi_i & irq_enable_i[0]}};
		end
	end

	assign irq_o = irq_q;
	assign nmi_o = nmi_q;

endmodule

/* verilog/pic_pkg.sv */
package pic_pkg;

	// ============================================================
	// sizes
	// ============================================================

	// line 0 is the nmi, lines 1 to 31 are maskable requests
	localparam int NUM_IRQ = 32;
	// one register port per core
	localparam int NUM_CORES = 2;

	typedef logic [4:0] irq_id_t;
	typedef logic [NUM_IRQ-1:0] irq_vec_t;
	typedef logic [7:0] cause_t;
	typedef logic [3:0] level_t;
	typedef logic [0:0] core_id_t;
	// byte offset within the controller
	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] word_t;

	// cause handed out by an acknowledge with nothing pending
	localparam cause_t SPURIOUS_CAUSE = 8'd24;
	// level each control word comes out of reset with
	localparam level_t LEVEL_RESET = 4'd8;

	// ============================================================
	// register map
	// ============================================================

	// global registers, word offsets (byte offset bits 7 to 2)
	localparam logic [5:0] REG_STATUS = 6'd0;
	localparam logic [5:0] REG_ENABLE = 6'd1;
	localparam logic [5:0] REG_DISABLE_ONE = 6'd2;
	localparam logic [5:0] REG_ENABLE_ONE = 6'd3;
	localparam logic [5:0] REG_EDGE_SENSE = 6'd4;
	localparam logic [5:0] REG_EDGE_RESET = 6'd5;
	localparam logic [5:0] REG_TRIGGER = 6'd6;
	// per-line words start here, one word per line
	localparam reg_addr_t REG_LINE_BASE = 8'h80;

	// bit positions in a per-line control word
	localparam int CTRL_ENABLE_BIT = 16;
	localparam int CTRL_SENSE_BIT = 17;
	localparam int CTRL_CORE_BIT = 24;

	// ============================================================
	// bundles
	// ============================================================

	// one register access, held until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic inta;
		reg_addr_t addr;
		word_t wdata;
	} reg_req_t;

	typedef struct packed {
		logic ack;
		word_t rdata;
	} reg_rsp_t;

	// routing data of one line
	typedef struct packed {
		cause_t cause;
		level_t level;
		core_id_t core;
	} line_ctrl_t;

	// what a core sees on its interrupt pins
	typedef struct packed {
		level_t level;
		cause_t cause;
	} core_irq_t;

	typedef enum logic [1:0] {
		IDLE,
		BUSY_CORE0,
		BUSY_CORE1
	} arb_state_t;

endpackage

/* verilog/pic_regs.sv */
`timescale 1ns/10ps

module pic_regs
(
	input logic clk,
	input logic rst_i,
	input pic_pkg::reg_req_t bus_req_i,
	output pic_pkg::reg_rsp_t bus_rsp_o,
	input pic_pkg::irq_id_t winner_i,
	input logic winner_valid_i,
	output pic_pkg::irq_vec_t irq_enable_o,
	output pic_pkg::irq_vec_t edge_sense_o,
	output pic_pkg::irq_vec_t edge_set_o,
	output pic_pkg::irq_vec_t edge_clear_o,
	output pic_pkg::line_ctrl_t line_ctrl_o [pic_pkg::NUM_IRQ]
);

	pic_pkg::irq_vec_t irq_enable_q;
	// 1 = edge sensitive, 0 = level sensitive
	pic_pkg::irq_vec_t edge_sense_q;
	pic_pkg::irq_vec_t edge_set_q;
	pic_pkg::irq_vec_t edge_clear_q;
	pic_pkg::line_ctrl_t line_ctrl_q [pic_pkg::NUM_IRQ];
	logic ack_q;
	pic_pkg::word_t rdata_q;

	logic access;
	logic line_sel;
	logic [5:0] word_sel;
	pic_pkg::irq_id_t line_idx;
	pic_pkg::irq_id_t data_idx;
	pic_pkg::word_t line_word;
	pic_pkg::word_t status_word;

	// first cycle of a granted access only, ack blocks a second hit
	assign access = bus_req_i.cyc & bus_req_i.stb & ~ack_q;

	// address decode
	assign line_sel = bus_req_i.addr >= pic_pkg::REG_LINE_BASE;
	assign word_sel = bus_req_i.addr[7:2];
	assign line_idx = bus_req_i.addr[6:2];
	// single-line registers name the line in the low data bits
	assign data_idx = bus_req_i.wdata[4:0];

	// read view of the addressed control word
	always_comb
	begin
		line_word = '0;
		line_word[7:0] = line_ctrl_q[line_idx].cause;
		line_word[11:8] = line_ctrl_q[line_idx].level;
		line_word[pic_pkg::CTRL_ENABLE_BIT] = irq_enable_q[line_idx];
		line_word[pic_pkg::CTRL_SENSE_BIT] = edge_sense_q[line_idx];
		line_word[pic_pkg::CTRL_CORE_BIT] = line_ctrl_q[line_idx].core;
	end

	// status shows the current winner's cause, zero when idle
	assign status_word = winner_valid_i ? pic_pkg::word_t'(line_ctrl_q[winner_i].cause) : '0;

	// ============================================================
	// write decode
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			irq_enable_q <= '0;
			// every line starts edge sensitive
			edge_sense_q <= '1;
			edge_set_q <= '0;
			edge_clear_q <= '0;
			for (int n = 0; n < pic_pkg::NUM_IRQ; n++)
			begin
				line_ctrl_q[n].cause <= '0;
				line_ctrl_q[n].level <= pic_pkg::LEVEL_RESET;
				line_ctrl_q[n].core <= '0;
			end
		end
		else
		begin
			// latch pulses last a single cycle
			edge_set_q <= '0;
			edge_clear_q <= '0;
			if (access && bus_req_i.inta)
			begin
				// acknowledge consumes the winner's edge latch
				if (winner_valid_i)
					edge_clear_q[winner_i] <= 1'b1;
			end
			else if (access && bus_req_i.we)
			begin
				if (line_sel)
				begin
					line_ctrl_q[line_idx].cause <= bus_req_i.wdata[7:0];
					line_ctrl_q[line_idx].level <= bus_req_i.wdata[11:8];
					line_ctrl_q[line_idx].core <= bus_req_i.wdata[pic_pkg::CTRL_CORE_BIT];
					irq_enable_q[line_idx] <= bus_req_i.wdata[pic_pkg::CTRL_ENABLE_BIT];
					edge_sense_q[line_idx] <= bus_req_i.wdata[pic_pkg::CTRL_SENSE_BIT];
				end
				else
				begin
					case (word_sel)
						// status is read only
						pic_pkg::REG_STATUS: ;
						pic_pkg::REG_ENABLE:
							irq_enable_q <= bus_req_i.wdata;
						pic_pkg::REG_DISABLE_ONE:
							irq_enable_q[data_idx] <= 1'b0;
						pic_pkg::REG_ENABLE_ONE:
							irq_enable_q[data_idx] <= 1'b1;
						pic_pkg::REG_EDGE_SENSE:
							edge_sense_q <= bus_req_i.wdata;
						pic_pkg::REG_EDGE_RESET:
							edge_clear_q[data_idx] <= 1'b1;
						pic_pkg::REG_TRIGGER:
							edge_set_q[data_idx] <= 1'b1;
						default: ;
					endcase
				end
			end
		end
	end

	// ============================================================
	// read data and ack
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (access && (bus_req_i.inta || !bus_req_i.we))
		begin
			if (bus_req_i.inta)
			begin
				// nothing pending gives the spurious cause
				if (winner_valid_i)
					rdata_q <= pic_pkg::word_t'(line_ctrl_q[winner_i].cause);
				else
					rdata_q <= pic_pkg::word_t'(pic_pkg::SPURIOUS_CAUSE);
			end
			else if (line_sel)
				rdata_q <= line_word;
			else
			begin
				case (word_sel)
					pic_pkg::REG_STATUS:
						rdata_q <= status_word;
					pic_pkg::REG_ENABLE:
						rdata_q <= irq_enable_q;
					default:
						rdata_q <= '0;
				endcase
			end
		end
	end

	// ack one cycle after the granted stb, reads and writes alike
	always_ff @(posedge clk)
	begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	assign bus_rsp_o.ack = ack_q;
	assign bus_rsp_o.rdata = rdata_q;

	assign irq_enable_o = irq_enable_q;
	assign edge_sense_o = edge_sense_q;
	assign edge_set_o = edge_set_q;
	assign edge_clear_o = edge_clear_q;
	assign line_ctrl_o = line_ctrl_q;

endmodule

/* verilog/pic_request_encoder.sv */
`timescale 1ns/10ps

module pic_request_encoder
(
	input logic clk,
	input logic rst_i,
	input pic_pkg::irq_vec_t irq_i,
	input pic_pkg::irq_vec_t irq_enable_i,
	input pic_pkg::irq_vec_t edge_sense_i,
	input pic_pkg::irq_vec_t edge_set_i,
	input pic_pkg::irq_vec_t edge_clear_i,
	output pic_pkg::irq_id_t winner_o,
	output logic winner_valid_o
);

	// sampled inputs and the copy one cycle older
	pic_pkg::irq_vec_t irq_s;
	pic_pkg::irq_vec_t irq_d;
	pic_pkg::irq_vec_t edge_q;
	pic_pkg::irq_vec_t pending;
	pic_pkg::irq_id_t next_id;
	logic next_valid;
	pic_pkg::irq_id_t winner_q;
	logic winner_valid_q;

	// raw lines are sampled once before anything looks at them
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			irq_s <= '0;
			irq_d <= '0;
		end
		else
		begin
			irq_s <= irq_i;
			irq_d <= irq_s;
		end
	end

	// ============================================================
	// edge latches
	// ============================================================

	// set on a rising sample or a software trigger
	// clear beats set in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst_i)
			edge_q <= '0;
		else
			edge_q <= (edge_q | (irq_s & ~irq_d) | edge_set_i) & ~edge_clear_i;
	end

	// edge lines use the latch, level lines the sampled input
	assign pending = irq_enable_i & ((edge_sense_i & edge_q) | (~edge_sense_i & irq_s));

	// ============================================================
	// priority encoder
	// ============================================================

	// lowest number wins, line 0 is left to the nmi path
	always_comb
	begin
		next_id = '0;
		next_valid = 1'b0;
		for (int n = pic_pkg::NUM_IRQ - 1; n > 0; n--)
		begin
			if (pending[n])
			begin
				next_id = pic_pkg::irq_id_t'(n);
				next_valid = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			winner_q <= '0;
			winner_valid_q <= 1'b0;
		end
		else
		begin
			winner_q <= next_id;
			winner_valid_q <= next_valid;
		end
	end

	assign winner_o = winner_q;
	assign winner_valid_o = winner_valid_q;

endmodule

/* verilog/pic_top.sv */
`timescale 1ns/10ps

module pic_top
(
	input logic clk,
	input logic rst_i,
	input pic_pkg::reg_req_t req_i [pic_pkg::NUM_CORES],
	output pic_pkg::reg_rsp_t rsp_o [pic_pkg::NUM_CORES],
	// bit 0 is unused, nmi arrives on nmi_i
	input pic_pkg::irq_vec_t irq_i,
	input logic nmi_i,
	output pic_pkg::core_irq_t irq_o [pic_pkg::NUM_CORES],
	output logic [pic_pkg::NUM_CORES-1:0] nmi_o
);

	// shared register bus after arbitration
	pic_pkg::reg_req_t bus_req;
	pic_pkg::reg_rsp_t bus_rsp;

	// control tables
	pic_pkg::irq_vec_t irq_enable;
	pic_pkg::irq_vec_t edge_sense;
	pic_pkg::irq_vec_t edge_set;
	pic_pkg::irq_vec_t edge_clear;
	pic_pkg::line_ctrl_t line_ctrl [pic_pkg::NUM_IRQ];

	// registered encoder result
	pic_pkg::irq_id_t winner;
	logic winner_valid;

	pic_bus_arbiter u_arbiter
	(
		.clk(clk),
		.rst_i(rst_i),
		.req_i(req_i),
		.rsp_o(rsp_o),
		.bus_req_o(bus_req),
		.bus_rsp_i(bus_rsp)
	);

	pic_regs u_regs
	(
		.clk(clk),
		.rst_i(rst_i),
		.bus_req_i(bus_req),
		.bus_rsp_o(bus_rsp),
		.winner_i(winner),
		.winner_valid_i(winner_valid),
		.irq_enable_o(irq_enable),
		.edge_sense_o(edge_sense),
		.edge_set_o(edge_set),
		.edge_clear_o(edge_clear),
		.line_ctrl_o(line_ctrl)
	);

	pic_request_encoder u_encoder
	(
		.clk(clk),
		.rst_i(rst_i),
		.irq_i(irq_i),
		.irq_enable_i(irq_enable),
		.edge_sense_i(edge_sense),
		.edge_set_i(edge_set),
		.edge_clear_i(edge_clear),
		.winner_o(winner),
		.winner_valid_o(winner_valid)
	);

	pic_core_router u_router
	(
		.clk(clk),
		.rst_i(rst_i),
		.winner_i(winner),
		.winner_valid_i(winner_valid),
		.line_ctrl_i(line_ctrl),
		.irq_enable_i(irq_enable),
		.nmi_i(nmi_i),
		.irq_o(irq_o),
		.nmi_o(nmi_o)
	);

endmodule
